// File: exec_defines.svh
// Shared widths and instruction encodings for the execute-stage slice.
// Covers data width, register count and the opcode and function field values.

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath and register file sizing.
`define EXEC_XLEN      32   // Width of every data word.
`define EXEC_NREGS     32   // Number of architectural registers.
`define EXEC_RADDR_W   5    // Bits needed to name one register.

// Opcode field values in bits 31 to 26 of the instruction.
`define EXEC_OP_RTYPE  6'h00  // All R-type ops share this opcode.
`define EXEC_OP_ADDI   6'h08  // Add immediate.

// Function field values in bits 5 to 0 of an R-type instruction.
`define EXEC_FN_ADD    6'h20
`define EXEC_FN_SUB    6'h22
`define EXEC_FN_AND    6'h24
`define EXEC_FN_OR     6'h25
`define EXEC_FN_SLT    6'h2a  // Signed set-less-than.

`endif

// File: exec_pkg.sv
// Types shared across the execute-stage slice.
// Holds the opcode and ALU enums, the ID/EX bundle and the write-back bundle.

`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Enumerations.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Primary opcode. Anything outside these two is treated as a no-op.
  typedef enum logic [5:0] {
    OP_RTYPE = `EXEC_OP_RTYPE,
    OP_ADDI  = `EXEC_OP_ADDI
  } opcode_e;

  // Operation the execute stage performs.
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,  // Also the value a bubble carries.
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pipeline bundles.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Decoded instruction as it travels from ID into EX. All zeros is a bubble.
  typedef struct packed {
    logic                       reg_write;  // Result goes to the register file.
    alu_op_e                    alu_op;
    logic                       alu_src;    // Second operand is the immediate.
    logic                       reg_dst;    // Destination is rd, not rt.
    logic [`EXEC_RADDR_W-1:0]   rs;
    logic [`EXEC_RADDR_W-1:0]   rt;
    logic [`EXEC_RADDR_W-1:0]   rd;
    logic [`EXEC_XLEN-1:0]      rd1;        // Value read for rs.
    logic [`EXEC_XLEN-1:0]      rd2;        // Value read for rt.
    logic [`EXEC_XLEN-1:0]      sign_imm;
  } id_ex_t;

  // Result leaving the EX/WB register.
  typedef struct packed {
    logic                       valid;
    logic [`EXEC_RADDR_W-1:0]   dest;
    logic [`EXEC_XLEN-1:0]      data;
  } wb_t;

endpackage

`default_nettype wire

// File: exec_regfile.sv
// Register file for the execute-stage slice.
// Two combinational read ports, one write port fed by write-back,
// write-through bypass, and r0 fixed at zero.

`default_nettype none

`include "exec_defines.svh"

module exec_regfile (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [`EXEC_RADDR_W-1:0]  ra1,
  input  logic [`EXEC_RADDR_W-1:0]  ra2,
  output logic [`EXEC_XLEN-1:0]     rd1,
  output logic [`EXEC_XLEN-1:0]     rd2,
  input  exec_pkg::wb_t             wb
);

  logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];  // The architectural registers.
  logic                  we;                  // Write strobe from write-back.

  // r0 is never written, so it keeps the zero it got at reset.
  assign we = wb.valid && (wb.dest != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        regs[i] <= '0;  // The machine starts with every register cleared.
      end
    end else if (we) begin
      regs[wb.dest] <= wb.data;
    end
  end

  // A value being written this cycle is passed straight to a matching read.
  assign rd1 = (ra1 == '0) ? '0 : (we && (wb.dest == ra1)) ? wb.data : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && (wb.dest == ra2)) ? wb.data : regs[ra2];

endmodule

`default_nettype wire

// File: exec_decode.sv
// Instruction intake and decode.
// Contains the Wishbone classic slave that accepts instruction words and
// the decoder that turns the latched word into an ID/EX bundle.

`default_nettype none

`include "exec_defines.svh"

module exec_decode (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`EXEC_XLEN-1:0]     wb_dat_w,
  output logic                      wb_ack,
  output logic [`EXEC_XLEN-1:0]     wb_dat_r,
  output logic [`EXEC_RADDR_W-1:0]  ra1,
  output logic [`EXEC_RADDR_W-1:0]  ra2,
  input  logic [`EXEC_XLEN-1:0]     rd1,
  input  logic [`EXEC_XLEN-1:0]     rd2,
  output exec_pkg::id_ex_t          id_bundle,
  output logic                      id_valid
);

  import exec_pkg::*;

  logic                  take;     // A new bus cycle is accepted this edge.
  logic                  fresh;    // instr_q holds a word not yet passed to ID/EX.
  logic [`EXEC_XLEN-1:0] instr_q;  // Last word written over the bus.
  opcode_e               opcode;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone classic slave.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign take = wb_cyc && wb_stb && !wb_ack;  // Ack low keeps one ack per cycle.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
      fresh  <= 1'b0;
    end else begin
      wb_ack <= take;            // High for exactly one cycle.
      fresh  <= take && wb_we;   // Reads are acked but issue nothing.
    end
  end

  always_ff @(posedge clk) begin
    if (take && wb_we) begin
      instr_q <= wb_dat_w;
    end
  end

  assign wb_dat_r = '0;  // There is nothing readable behind this slave.
  assign id_valid = fresh;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decoder.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign opcode = opcode_e'(instr_q[31:26]);
  assign ra1    = instr_q[25:21];  // rs.
  assign ra2    = instr_q[20:16];  // rt.

  always_comb begin
    id_bundle          = '0;
    id_bundle.rs       = instr_q[25:21];
    id_bundle.rt       = instr_q[20:16];
    id_bundle.rd       = instr_q[15:11];
    id_bundle.rd1      = rd1;
    id_bundle.rd2      = rd2;
    id_bundle.sign_imm = {{(`EXEC_XLEN-16){instr_q[15]}}, instr_q[15:0]};
    case (opcode)
      OP_RTYPE: begin
        id_bundle.reg_dst   = 1'b1;  // R-type writes rd.
        id_bundle.reg_write = 1'b1;
        case (instr_q[5:0])
          `EXEC_FN_ADD: id_bundle.alu_op = ALU_ADD;
          `EXEC_FN_SUB: id_bundle.alu_op = ALU_SUB;
          `EXEC_FN_AND: id_bundle.alu_op = ALU_AND;
          `EXEC_FN_OR:  id_bundle.alu_op = ALU_OR;
          `EXEC_FN_SLT: id_bundle.alu_op = ALU_SLT;
          default:      id_bundle.reg_write = 1'b0;  // Unknown funct is a no-op.
        endcase
      end
      OP_ADDI: begin
        id_bundle.reg_write = 1'b1;
        id_bundle.alu_src   = 1'b1;  // Immediate replaces rt's value.
        id_bundle.alu_op    = ALU_ADD;
      end
      default: id_bundle.reg_write = 1'b0;  // Unknown opcodes write nothing.
    endcase
  end

endmodule

`default_nettype wire

// File: exec_id_ex_reg.sv
// ID/EX pipeline register.
// Holds one decoded bundle and falls back to a bubble when decode
// has nothing new to offer.

`default_nettype none

module exec_id_ex_reg (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             id_valid,   // Decode holds a freshly accepted word.
  input  exec_pkg::id_ex_t id_bundle,  // Bundle built by decode this cycle.
  output exec_pkg::id_ex_t ex_bundle   // Bundle seen by the execute stage.
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A bubble is the all-zero bundle. It has reg_write low, so whatever
  // the ALU makes of it never reaches the register file.
  //
  // Decode presents the same word for only one cycle after the bus ack.
  // Loading it once and then clearing keeps each instruction from
  // executing twice while the bus is idle.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_bundle <= '0;          // Start out empty.
    end else if (!id_valid) begin
      ex_bundle <= '0;          // Nothing accepted, insert a bubble.
    end else begin
      ex_bundle <= id_bundle;   // Advance the decoded instruction.
    end
  end

  // Operand values are captured here together with their control bits.
  // Any write that lands in the register file after this edge is
  // covered by the forwarding path in the execute stage.

  // There is no stall input. With no load-use or branch hazards in this
  // slice, the register always advances on every edge.

endmodule

`default_nettype wire

// File: exec_alu_stage.sv
// Execute stage.
// Forwarding from the EX/WB register, operand selection, the ALU
// and the EX/WB register that drives the write-back bundle.

`default_nettype none

`include "exec_defines.svh"

module exec_alu_stage (
  input  logic             clk,
  input  logic             arst_n,
  input  exec_pkg::id_ex_t ex_bundle,
  output exec_pkg::wb_t    wb
);

  import exec_pkg::*;

  logic [`EXEC_XLEN-1:0]    src_a;    // rs value after forwarding.
  logic [`EXEC_XLEN-1:0]    fwd_b;    // rt value after forwarding.
  logic [`EXEC_XLEN-1:0]    src_b;    // Second ALU input.
  logic [`EXEC_XLEN-1:0]    result;
  logic [`EXEC_RADDR_W-1:0] dest;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand selection.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The older instruction in EX/WB may target a register that this one
  // read too early. Its result overrides the stale value.
  always_comb begin
    src_a = ex_bundle.rd1;
    fwd_b = ex_bundle.rd2;
    if (wb.valid && (wb.dest != '0) && (wb.dest == ex_bundle.rs)) src_a = wb.data;
    if (wb.valid && (wb.dest != '0) && (wb.dest == ex_bundle.rt)) fwd_b = wb.data;
  end

  assign src_b = ex_bundle.alu_src ? ex_bundle.sign_imm : fwd_b;
  assign dest  = ex_bundle.reg_dst ? ex_bundle.rd : ex_bundle.rt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU and EX/WB register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (ex_bundle.alu_op)
      ALU_ADD: result = src_a + src_b;
      ALU_SUB: result = src_a - src_b;
      ALU_AND: result = src_a & src_b;
      ALU_OR:  result = src_a | src_b;
      ALU_SLT: result = {{(`EXEC_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      default: result = '0;  // Not produced by decode.
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb <= '0;
    end else begin
      wb.valid <= ex_bundle.reg_write && (dest != '0);  // r0 writes are dropped.
      wb.dest  <= dest;
      wb.data  <= result;
    end
  end

endmodule

`default_nettype wire

// File: exec_top.sv
// Top level of the execute-stage slice.
// Connects the bus slave and decoder, the register file, the ID/EX
// register and the execute stage, and exposes the write-back port.

`default_nettype none

`include "exec_defines.svh"

module exec_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`EXEC_XLEN-1:0]     wb_dat_w,
  output logic                      wb_ack,
  output logic [`EXEC_XLEN-1:0]     wb_dat_r,
  output logic                      wb_valid,
  output logic [`EXEC_RADDR_W-1:0]  wb_dest,
  output logic [`EXEC_XLEN-1:0]     wb_data
);

  import exec_pkg::*;

  logic [`EXEC_RADDR_W-1:0] ra1, ra2;   // Read addresses from decode.
  logic [`EXEC_XLEN-1:0]    rd1, rd2;   // Read data back to decode.
  id_ex_t                   id_bundle;
  logic                     id_valid;
  id_ex_t                   ex_bundle;
  wb_t                      wb_bundle;  // Feeds the register file and the ports.

  exec_decode u_decode (
    .clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_dat_w, .wb_ack, .wb_dat_r,
    .ra1, .ra2, .rd1, .rd2, .id_bundle, .id_valid
  );

  exec_regfile u_regfile (
    .clk, .arst_n, .ra1, .ra2, .rd1, .rd2, .wb(wb_bundle)
  );

  exec_id_ex_reg u_id_ex (
    .clk, .arst_n, .id_valid, .id_bundle, .ex_bundle
  );

  exec_alu_stage u_alu (
    .clk, .arst_n, .ex_bundle, .wb(wb_bundle)
  );

  assign wb_valid = wb_bundle.valid;
  assign wb_dest  = wb_bundle.dest;
  assign wb_data  = wb_bundle.data;

endmodule

`default_nettype wire

// File: tb_exec_checker.sv
// Result checker for the execute-stage testbench.
// Queues the expected result of every acked word, checks the bus read
// data during the ack and compares the write-back port two cycles later.

`default_nettype none

`include "exec_defines.svh"

module tb_exec_checker (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      wb_ack,
  input  logic [`EXEC_XLEN-1:0]     wb_dat_r,
  input  logic                      wb_valid,
  input  logic [`EXEC_RADDR_W-1:0]  wb_dest,
  input  logic [`EXEC_XLEN-1:0]     wb_data,
  input  exec_pkg::wb_t             expect_bus,  // Expected result of the word on the bus.
  output int                        n_checked,
  output int                        n_failed,
  output int                        n_stray
);

  import exec_pkg::*;

  localparam int LATENCY = 2;  // Cycles from the ack to the write-back.

  // One issued word that still waits for its result.
  typedef struct packed {
    int   idx;      // Line number of the word among the tests.
    int   due;      // Cycle at which its result must be on the port.
    wb_t  exp;
    logic bus_bad;  // The slave returned nonzero read data during the ack.
  } pending_t;

  pending_t pending[$];  // Oldest entry first, matching issue order.
  int       cycle;
  int       n_issued;

  // Compares the write-back port with one expected entry.
  task automatic check_entry(input pending_t e);
    logic bad;
    bad = e.bus_bad;
    if (e.exp.valid) begin
      if (wb_valid !== 1'b1) begin
        $display("ERROR at time %0t: test %0d expected a write to r%0d but no write-back came",
                 $time, e.idx, e.exp.dest);
        bad = 1'b1;
      end else begin
        if (wb_dest !== e.exp.dest) begin
          $display("MISMATCH at time %0t: wb_dest expected %0d, actual %0d",
                   $time, e.exp.dest, wb_dest);
          bad = 1'b1;
        end
        if (wb_data !== e.exp.data) begin
          $display("MISMATCH at time %0t: wb_data expected %h, actual %h",
                   $time, e.exp.data, wb_data);
          bad = 1'b1;
        end
      end
    end else if (wb_valid !== 1'b0) begin
      $display("ERROR at time %0t: test %0d should write nothing but wrote r%0d",
               $time, e.idx, wb_dest);
      bad = 1'b1;
    end
    n_checked++;
    if (bad) n_failed++;
    $display("test %0d %s", e.idx, bad ? "FAILED" : "passed");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sampling on the falling edge, where the DUT outputs are settled.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    pending_t entry;
    if (!arst_n) begin
      cycle     = 0;
      n_issued  = 0;
      n_checked = 0;
      n_failed  = 0;
      n_stray   = 0;
      pending.delete();
    end else begin
      cycle++;
      if (pending.size() > 0 && pending[0].due == cycle) begin
        check_entry(pending.pop_front());
      end else if (wb_valid !== 1'b0) begin
        // A result with nothing due means an extra or early write-back.
        $display("ERROR at time %0t: write-back to r%0d with no instruction due",
                 $time, wb_dest);
        n_stray++;
      end
      if (wb_ack === 1'b1) begin
        n_issued++;
        entry.idx     = n_issued;
        entry.due     = cycle + LATENCY;  // The ack is seen one edge after it rose.
        entry.exp     = expect_bus;
        entry.bus_bad = 1'b0;
        // Nothing is readable behind the slave, so its read data is always zero.
        if (wb_dat_r !== '0) begin
          $display("MISMATCH at time %0t: wb_dat_r expected %h, actual %h",
                   $time, {`EXEC_XLEN{1'b0}}, wb_dat_r);
          entry.bus_bad = 1'b1;
        end
        pending.push_back(entry);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_exec.sv
// Testbench top for the execute-stage slice.
// Clock and reset, a Wishbone master fed from the stimulus file, and the final report.

`default_nettype none

`include "exec_defines.svh"

module tb_exec;

  import exec_pkg::*;

  localparam int ACK_TIMEOUT   = 20;  // Cycles to wait for one bus ack.
  localparam int DRAIN_TIMEOUT = 20;  // Cycles to wait for the last results.

  logic                     clk;
  logic                     arst_n;
  logic                     wb_cyc, wb_stb, wb_we;
  logic [`EXEC_XLEN-1:0]    wb_dat_w, wb_dat_r;
  logic                     wb_ack, wb_valid;
  logic [`EXEC_RADDR_W-1:0] wb_dest;
  logic [`EXEC_XLEN-1:0]    wb_data;
  wb_t                      expect_bus;  // Travels with the word to the checker.
  int                       n_checked, n_failed, n_stray;

  exec_top exec_top_i (
    .clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_dat_w, .wb_ack, .wb_dat_r,
    .wb_valid, .wb_dest, .wb_data
  );

  tb_exec_checker checker_i (
    .clk, .arst_n, .wb_ack, .wb_dat_r, .wb_valid, .wb_dest, .wb_data, .expect_bus,
    .n_checked, .n_failed, .n_stray
  );

  always #50 clk = ~clk;  // Period of 100.

  // Writes one word over the bus. Inputs change 10 units after a rising edge.
  task automatic issue_word(input logic [`EXEC_XLEN-1:0] word, input int idle,
                            output logic acked);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_dat_w = word;
    acked    = 1'b0;
    waited   = 0;
    while (!acked && waited < ACK_TIMEOUT) begin
      @(posedge clk);
      #10;
      waited++;
      acked = (wb_ack === 1'b1);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (acked) begin
      repeat (idle + 1) begin  // One cycle with stb low, then the extra idle time.
        @(posedge clk);
        #10;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int                       fd;
    int                       rc;
    int                       n_tests;
    int                       idle;
    int                       wr_flag;
    int                       waited;
    string                    line;
    logic [`EXEC_XLEN-1:0]    instr;
    logic [`EXEC_RADDR_W-1:0] dest;
    logic [`EXEC_XLEN-1:0]    value;
    logic                     acked;
    logic                     run_ok;
    clk        = 1'b0;
    arst_n     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_dat_w   = '0;
    expect_bus = '0;
    n_tests    = 0;
    run_ok     = 1'b1;
    repeat (4) @(posedge clk);
    #10;
    arst_n = 1'b1;

    fd = $fopen("exec_stimulus.txt", "r");
    if (fd == 0) begin
      $display("ERROR: the stimulus file exec_stimulus.txt could not be opened");
      run_ok = 1'b0;
    end
    while (run_ok && fd != 0 && !$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line[0] != "#") begin  // Lines starting with # are notes.
        rc = $sscanf(line, "%h %d %d %h %h", instr, idle, wr_flag, dest, value);
        if (rc == 5) begin
          expect_bus.valid = (wr_flag != 0);
          expect_bus.dest  = dest;
          expect_bus.data  = value;
          issue_word(instr, idle, acked);
          n_tests++;
          if (!acked) begin
            $display("ERROR: no bus acknowledge for word %h within %0d cycles",
                     instr, ACK_TIMEOUT);
            run_ok = 1'b0;
          end
        end
      end
    end
    if (fd != 0) $fclose(fd);

    // Results of the last words are still in flight.
    waited = 0;
    while (run_ok && n_checked < n_tests && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (run_ok && n_checked < n_tests) begin
      $display("ERROR: only %0d of %0d results were checked before the timeout",
               n_checked, n_tests);
      run_ok = 1'b0;
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d, stray write-backs: %0d",
             n_tests, n_checked - n_failed, n_failed, n_stray);
    if (run_ok && n_tests > 0 && n_failed == 0 && n_stray == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
exec_pkg.sv
exec_regfile.sv
exec_decode.sv
exec_id_ex_reg.sv
exec_alu_stage.sv
exec_top.sv
tb_exec_checker.sv
tb_exec.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_exec -o tb_exec_sim \
  > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }

./obj_dir/tb_exec_sim > sim.log 2>&1 || { cat sim.log; echo "RUN FAILED"; exit 1; }

cat sim.log
grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: exec_stimulus.txt
# Columns: instruction word (hex), idle cycles after the bus cycle, write expected (0 or 1),
#          destination register (hex), expected write-back value (hex).
20010005 0 1 01 00000005
2022fffd 0 1 02 00000002
2003ff9c 2 1 03 ffffff9c
00222020 0 1 04 00000007
00432822 1 1 05 00000066
00643024 1 1 06 00000004
00653825 2 1 07 fffffffe
0061402a 0 1 08 00000001
0023482a 0 1 09 00000000
00220020 0 0 00 00000000
20200009 0 0 00 00000000
00005020 1 1 0a 00000000
fc2a0001 0 0 00 00000000
0022583f 0 0 00 00000000
00275820 0 1 0b 00000003
01646022 0 1 0c fffffffc
218c7fff 1 1 0c 00007ffb
0183682a 2 1 0d 00000000
01857024 0 1 0e 00000062
